//--- rtl/buffer_port_mux.sv
`default_nettype none

module buffer_port_mux (
  input  wire                          clk,
  input  wire                          xrst,
  ddr_burst_if.port                    pre_bus,
  ddr_burst_if.port                    post_bus,
  input  wire ddr_buf_pkg::word_t      pre_word,
  input  wire logic                    last_we,
  input  wire ddr_buf_pkg::word_t      last_wdata,
  input  wire logic                    ddr_we,
  input  wire ddr_buf_pkg::buf_addr_t  ddr_waddr,
  input  wire ddr_buf_pkg::beat_t      ddr_wdata,
  input  wire ddr_buf_pkg::buf_addr_t  ddr_raddr,
  output logic                         ddr_req,
  output ddr_buf_pkg::ddr_mode_e       ddr_mode,
  output ddr_buf_pkg::addr_t           ddr_base,
  output ddr_buf_pkg::len_t            ddr_len,
  output ddr_buf_pkg::beat_t           ddr_rdata,
  output ddr_buf_pkg::word_t           mem_rdata
);
  import ddr_buf_pkg::*;

  logic      hold_q;
  ddr_mode_e hold_mode_q;
  addr_t     hold_base_q;
  len_t      hold_len_q;
  buf_addr_t raddr_q;

  // ==========================================================================
  // request arbitration
  // ==========================================================================

  // read wins, a colliding write goes one cycle later
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_req  <= 1'b0;
      ddr_mode <= DDR_READ;
      ddr_base <= '0;
      ddr_len  <= '0;
      hold_q   <= 1'b0;
    end else begin
      ddr_req <= pre_bus.req || post_bus.req || hold_q;
      hold_q  <= pre_bus.req && (post_bus.req || hold_q);
      if (pre_bus.req) begin
        ddr_mode <= pre_bus.mode;
        ddr_base <= pre_bus.base;
        ddr_len  <= pre_bus.len;
      end else if (hold_q) begin
        ddr_mode <= hold_mode_q;
        ddr_base <= hold_base_q;
        ddr_len  <= hold_len_q;
      end else if (post_bus.req) begin
        ddr_mode <= post_bus.mode;
        ddr_base <= post_bus.base;
        ddr_len  <= post_bus.len;
      end
    end
  end

  // copy of the write request
  always_ff @(posedge clk) begin
    if (post_bus.req) begin
      hold_mode_q <= post_bus.mode;
      hold_base_q <= post_bus.base;
      hold_len_q  <= post_bus.len;
    end
  end

  // ==========================================================================
  // beat routing
  // ==========================================================================

  // fill beats go straight to the prefetch buffer
  assign pre_bus.we    = ddr_we;
  assign pre_bus.addr  = ddr_waddr;
  assign pre_bus.wdata = ddr_wdata;

  // drain is read only
  always_ff @(posedge clk) begin
    raddr_q <= ddr_raddr;
  end

  assign post_bus.we    = 1'b0;
  assign post_bus.addr  = raddr_q;
  assign post_bus.wdata = '0;

  assign ddr_rdata = post_bus.rdata;

  // word written last cycle beats the buffer
  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_rdata <= '0;
    end else begin
      mem_rdata <= last_we ? last_wdata : pre_word;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ddr_buf_defines.svh
`ifndef DDR_BUF_DEFINES_SVH
`define DDR_BUF_DEFINES_SVH

// ==========================================================================
// word and beat geometry
// ==========================================================================

// scratch memory word
`define DWIDTH    16

// words per ddr beat
`define RATE      4
`define RATELOG   2

// earliest word sits in the top slot
`define BWIDTH    (`RATE*`DWIDTH)

// ==========================================================================
// burst and address sizing
// ==========================================================================

// beats per burst, one burst per transfer
`define BURST_MAX 8

// beat index bits inside a buffer
`define BUFSIZE   3

// word address bits
`define IMGSIZE   16

// up to RATE*BURST_MAX words
`define LWIDTH    6

`endif

//--- rtl/ddr_buf_pkg.sv
`default_nettype none

`include "ddr_buf_defines.svh"

package ddr_buf_pkg;

  // data
  typedef logic signed [`DWIDTH-1:0] word_t;
  typedef logic [`BWIDTH-1:0]        beat_t;

  // addresses and lengths
  typedef logic [`IMGSIZE-1:0]       addr_t;
  typedef logic [`LWIDTH-1:0]        len_t;
  typedef logic [`BUFSIZE-1:0]       buf_addr_t;

  typedef enum logic {
    DDR_READ  = 1'b0,
    DDR_WRITE = 1'b1
  } ddr_mode_e;

  typedef enum logic [1:0] {
    PK_IDLE = 2'd0,
    PK_FILL = 2'd1,
    PK_REQ  = 2'd2
  } pack_state_e;

  // words to beats, rounded up
  function automatic len_t beat_count(input len_t words);
    return len_t'(words[`LWIDTH-1:`RATELOG]) + len_t'(|words[`RATELOG-1:0]);
  endfunction

endpackage

`default_nettype wire

//--- rtl/ddr_buf_top.sv
`default_nettype none

module ddr_buf_top (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire logic                    pre_en,
  input  wire ddr_buf_pkg::addr_t      pre_base,
  input  wire ddr_buf_pkg::len_t       read_len,
  input  wire ddr_buf_pkg::len_t       write_len,
  input  wire logic                    mem_we,
  input  wire ddr_buf_pkg::addr_t      mem_addr,
  input  wire ddr_buf_pkg::word_t      mem_wdata,
  input  wire logic                    ddr_we,
  input  wire ddr_buf_pkg::buf_addr_t  ddr_waddr,
  input  wire ddr_buf_pkg::beat_t      ddr_wdata,
  input  wire ddr_buf_pkg::buf_addr_t  ddr_raddr,
  output logic                         ddr_req,
  output ddr_buf_pkg::ddr_mode_e       ddr_mode,
  output ddr_buf_pkg::addr_t           ddr_base,
  output ddr_buf_pkg::len_t            ddr_len,
  output ddr_buf_pkg::beat_t           ddr_rdata,
  output ddr_buf_pkg::word_t           mem_rdata
);
  import ddr_buf_pkg::*;

  word_t pre_word;
  logic  last_we;
  word_t last_wdata;

  ddr_burst_if pre_bus ();
  ddr_burst_if post_bus ();

  prefetch_buffer prefetch_buffer_inst (
    .clk      (clk),
    .xrst     (xrst),
    .pre_en   (pre_en),
    .pre_base (pre_base),
    .read_len (read_len),
    .mem_addr (mem_addr),
    .pre_word (pre_word),
    .bus      (pre_bus.side)
  );

  write_packer write_packer_inst (
    .clk        (clk),
    .xrst       (xrst),
    .pre_en     (pre_en),
    .write_len  (write_len),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .last_we    (last_we),
    .last_wdata (last_wdata),
    .bus        (post_bus.side)
  );

  buffer_port_mux buffer_port_mux_inst (
    .clk        (clk),
    .xrst       (xrst),
    .pre_bus    (pre_bus.port),
    .post_bus   (post_bus.port),
    .pre_word   (pre_word),
    .last_we    (last_we),
    .last_wdata (last_wdata),
    .ddr_we     (ddr_we),
    .ddr_waddr  (ddr_waddr),
    .ddr_wdata  (ddr_wdata),
    .ddr_raddr  (ddr_raddr),
    .ddr_req    (ddr_req),
    .ddr_mode   (ddr_mode),
    .ddr_base   (ddr_base),
    .ddr_len    (ddr_len),
    .ddr_rdata  (ddr_rdata),
    .mem_rdata  (mem_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/ddr_burst_if.sv
`default_nettype none

interface ddr_burst_if;
  import ddr_buf_pkg::*;

  // request, valid only while req is high
  logic      req;
  ddr_mode_e mode;
  addr_t     base;
  len_t      len;

  // beat traffic between buffer and ddr master
  logic      we;
  buf_addr_t addr;
  beat_t     wdata;
  beat_t     rdata;

  // buffer side
  modport side (
    output req,
    output mode,
    output base,
    output len,
    output rdata,
    input  we,
    input  addr,
    input  wdata
  );

  // arbiter side
  modport port (
    input  req,
    input  mode,
    input  base,
    input  len,
    input  rdata,
    output we,
    output addr,
    output wdata
  );

endinterface

`default_nettype wire

//--- rtl/prefetch_buffer.sv
`default_nettype none

`include "ddr_buf_defines.svh"

module prefetch_buffer (
  input  wire                      clk,
  input  wire                      xrst,
  input  wire logic                pre_en,
  input  wire ddr_buf_pkg::addr_t  pre_base,
  input  wire ddr_buf_pkg::len_t   read_len,
  input  wire ddr_buf_pkg::addr_t  mem_addr,
  output ddr_buf_pkg::word_t       pre_word,
  ddr_burst_if.side                bus
);
  import ddr_buf_pkg::*;

  logic                req_q;
  addr_t               base_q;
  len_t                len_q;
  logic                filled_q;
  addr_t               offset;
  buf_addr_t           ram_addr;
  beat_t               ram_rdata;
  logic [`RATELOG-1:0] word_sel_q;

  // ==========================================================================
  // read request
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q  <= 1'b0;
      base_q <= '0;
      len_q  <= '0;
    end else begin
      req_q <= pre_en;
      if (pre_en) begin
        base_q <= pre_base;
        len_q  <= beat_count(read_len);
      end
    end
  end

  assign bus.req  = req_q;
  assign bus.mode = DDR_READ;
  assign bus.base = base_q;
  assign bus.len  = len_q;

  // ==========================================================================
  // buffer
  // ==========================================================================

  // nothing valid until the first beat lands
  always_ff @(posedge clk) begin
    if (!xrst) begin
      filled_q <= 1'b0;
    end else if (bus.we) begin
      filled_q <= 1'b1;
    end
  end

  assign offset   = mem_addr - base_q;
  // fill beats take the port
  assign ram_addr = bus.we ? bus.addr : offset[`BUFSIZE+`RATELOG-1:`RATELOG];

  sp_ram #(
    .WIDTH     (`BWIDTH),
    .DEPTH_LOG (`BUFSIZE)
  ) pre_ram (
    .clk   (clk),
    .we    (bus.we),
    .addr  (ram_addr),
    .wdata (bus.wdata),
    .rdata (ram_rdata)
  );

  always_ff @(posedge clk) begin
    word_sel_q <= offset[`RATELOG-1:0];
  end

  // slot 0 is the top word
  assign pre_word  = filled_q ? ram_rdata[`BWIDTH-1-word_sel_q*`DWIDTH -: `DWIDTH] : '0;
  assign bus.rdata = ram_rdata;

endmodule

`default_nettype wire

//--- rtl/sp_ram.sv
`default_nettype none

module sp_ram #(
  parameter int WIDTH     = $bits(ddr_buf_pkg::beat_t),
  parameter int DEPTH_LOG = $bits(ddr_buf_pkg::buf_addr_t)
) (
  input  wire logic                 clk,
  input  wire logic                 we,
  input  wire logic [DEPTH_LOG-1:0] addr,
  input  wire logic [WIDTH-1:0]     wdata,
  output logic      [WIDTH-1:0]     rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, old data on a write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

//--- rtl/write_packer.sv
`default_nettype none

`include "ddr_buf_defines.svh"

module write_packer (
  input  wire                      clk,
  input  wire                      xrst,
  input  wire logic                pre_en,
  input  wire ddr_buf_pkg::len_t   write_len,
  input  wire logic                mem_we,
  input  wire ddr_buf_pkg::addr_t  mem_addr,
  input  wire ddr_buf_pkg::word_t  mem_wdata,
  output logic                     last_we,
  output ddr_buf_pkg::word_t       last_wdata,
  ddr_burst_if.side                bus
);
  import ddr_buf_pkg::*;

  pack_state_e         state_q;
  len_t                write_len_q;
  len_t                cnt_q;
  addr_t               base_q;
  beat_t               beat_q;
  logic                wr_pending_q;
  buf_addr_t           wr_addr_q;
  logic                req_q;
  logic                accept;
  logic                last_word;
  logic [`RATELOG-1:0] slot;
  buf_addr_t           ram_addr;
  beat_t               ram_rdata;

  assign accept    = mem_we && state_q != PK_REQ;
  assign last_word = len_t'(cnt_q + 1'b1) == write_len_q;
  assign slot      = cnt_q[`RATELOG-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      write_len_q <= '0;
    end else if (pre_en) begin
      write_len_q <= write_len;
    end
  end

  // ==========================================================================
  // transaction control
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_q <= PK_IDLE;
      req_q   <= 1'b0;
    end else begin
      req_q <= 1'b0;
      case (state_q)
        PK_IDLE: begin
          if (mem_we) begin
            state_q <= last_word ? PK_REQ : PK_FILL;
          end
        end
        PK_FILL: begin
          if (mem_we && last_word) begin
            state_q <= PK_REQ;
          end
        end
        // last beat is in the buffer by now
        PK_REQ: begin
          state_q <= PK_IDLE;
          req_q   <= 1'b1;
        end
        default: begin
          state_q <= PK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cnt_q <= '0;
    end else if (state_q == PK_REQ) begin
      cnt_q <= '0;
    end else if (mem_we) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // first word sets the burst base
  always_ff @(posedge clk) begin
    if (state_q == PK_IDLE && mem_we) begin
      base_q <= mem_addr;
    end
  end

  // ==========================================================================
  // packing
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      if (slot == '0) begin
        beat_q <= {mem_wdata, {(`BWIDTH-`DWIDTH){1'b0}}};
      end else begin
        beat_q[`BWIDTH-1-slot*`DWIDTH -: `DWIDTH] <= mem_wdata;
      end
    end
  end

  // full beat or short last one
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_pending_q <= 1'b0;
    end else begin
      wr_pending_q <= accept && (slot == `RATELOG'(`RATE-1) || last_word);
    end
  end

  always_ff @(posedge clk) begin
    wr_addr_q <= cnt_q[`BUFSIZE+`RATELOG-1:`RATELOG];
  end

  assign ram_addr = wr_pending_q ? wr_addr_q : bus.addr;

  sp_ram #(
    .WIDTH     (`BWIDTH),
    .DEPTH_LOG (`BUFSIZE)
  ) post_ram (
    .clk   (clk),
    .we    (wr_pending_q),
    .addr  (ram_addr),
    .wdata (beat_q),
    .rdata (ram_rdata)
  );

  assign bus.req   = req_q;
  assign bus.mode  = DDR_WRITE;
  assign bus.base  = base_q;
  assign bus.len   = beat_count(write_len_q);
  assign bus.rdata = ram_rdata;

  // for the read bypass
  always_ff @(posedge clk) begin
    if (!xrst) begin
      last_we <= 1'b0;
    end else begin
      last_we <= mem_we;
    end
  end

  always_ff @(posedge clk) begin
    last_wdata <= mem_wdata;
  end

endmodule

`default_nettype wire

//--- verif/ddr_buf_props.sv
`default_nettype none

`include "ddr_buf_defines.svh"

module ddr_buf_props (
  input wire logic              clk,
  input wire logic              xrst,
  input wire logic              ddr_req,
  input wire ddr_buf_pkg::len_t ddr_len
);
  timeunit 1ns;
  timeprecision 1ps;

  // failures seen so far
  int fail_count = 0;

  req_known: assert property (@(posedge clk) disable iff (!xrst) !$isunknown(ddr_req))
    else begin
      $error("ddr_req is unknown after reset");
      fail_count++;
    end

  // one burst never exceeds the buffer
  len_in_range: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |-> (ddr_len >= 1 && ddr_len <= `BURST_MAX))
    else begin
      $error("ddr_len out of range during a request");
      fail_count++;
    end

  // read plus one held write at most
  req_run: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req ##1 ddr_req |=> !ddr_req)
    else begin
      $error("more than two request cycles in a row");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verif/tb_ddr_buf.sv
`default_nettype none

`include "ddr_buf_defines.svh"

module tb_ddr_buf;
  timeunit 1ns;
  timeprecision 1ps;
  import ddr_buf_pkg::*;

  localparam int TIMEOUT = 1200;
  localparam int SEED    = 46069;

  logic               clk = 1'b0;
  logic               xrst;
  logic               pre_en;
  addr_t              pre_base;
  len_t               read_len;
  len_t               write_len;
  logic               mem_we;
  addr_t              mem_addr;
  logic [`DWIDTH-1:0] mem_wdata;
  logic               ddr_we;
  buf_addr_t          ddr_waddr;
  beat_t              ddr_wdata;
  buf_addr_t          ddr_raddr;
  logic               ddr_req;
  ddr_mode_e          ddr_mode;
  addr_t              ddr_base;
  len_t               ddr_len;
  beat_t              ddr_rdata;
  logic [`DWIDTH-1:0] mem_rdata;
  int                 cycles = 0;
  logic [`DWIDTH-1:0] words [`RATE*`BURST_MAX];
  beat_t              fill [`BURST_MAX];

  ddr_buf_top ddr_buf_top_inst (.*);

  bind ddr_buf_top ddr_buf_props ddr_buf_props_inst (
    .clk     (clk),
    .xrst    (xrst),
    .ddr_req (ddr_req),
    .ddr_len (ddr_len)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [`BWIDTH-1:0] got,
                       input logic [`BWIDTH-1:0] exp);
    if (got !== exp) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_req(input ddr_mode_e mode, input addr_t base, input len_t len);
    check("ddr_req", ddr_req, 1'b1);
    check("ddr_mode", ddr_mode, mode);
    check("ddr_base", ddr_base, base);
    check("ddr_len", ddr_len, len);
  endtask

  // earliest word on top and zeros past the last word
  function automatic beat_t beat_of(input int first, input int count);
    beat_t b;
    b = '0;
    for (int s = 0; s < `RATE; s++) begin
      b = {b[`BWIDTH-`DWIDTH-1:0], (s < count) ? words[first+s] : `DWIDTH'(0)};
    end
    return b;
  endfunction

  task automatic pulse_prefetch(input addr_t base, input len_t rlen, input len_t wlen);
    pre_en    = 1'b1;
    pre_base  = base;
    read_len  = rlen;
    write_len = wlen;
    tick();
    pre_en = 1'b0;
    check("ddr_req", ddr_req, 1'b0);
    tick();
    check_req(DDR_READ, base, len_t'((rlen + `RATE - 1) / `RATE));
    tick();
    check("ddr_req", ddr_req, 1'b0);
  endtask

  task automatic write_words(input addr_t base, input int n);
    for (int i = 0; i < n; i++) begin
      words[i]  = `DWIDTH'($urandom);
      mem_we    = 1'b1;
      mem_addr  = base + addr_t'(i);
      mem_wdata = words[i];
      tick();
    end
  endtask

  task automatic drain_beats(input int nwords);
    int nbeats;
    int count;
    nbeats = (nwords + `RATE - 1) / `RATE;
    for (int k = 0; k < nbeats; k++) begin
      count     = (nwords - k*`RATE < `RATE) ? nwords - k*`RATE : `RATE;
      ddr_raddr = buf_addr_t'(k);
      tick();
      tick();
      check("ddr_rdata", ddr_rdata, beat_of(k*`RATE, count));
    end
  endtask

  // write request lands two cycles after the last word
  task automatic write_and_drain(input addr_t base, input int n);
    write_words(base, n);
    mem_we = 1'b0;
    tick();
    check("ddr_req", ddr_req, 1'b0);
    tick();
    check_req(DDR_WRITE, base, len_t'((n + `RATE - 1) / `RATE));
    tick();
    check("ddr_req", ddr_req, 1'b0);
    drain_beats(n);
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic reset_values();
    check("ddr_req", ddr_req, 1'b0);
    check("ddr_mode", ddr_mode, DDR_READ);
    check("ddr_base", ddr_base, '0);
    check("ddr_len", ddr_len, '0);
    check("mem_rdata", mem_rdata, '0);
  endtask

  // base off a beat boundary so the offset matters
  task automatic prefetch_fill_read();
    addr_t base;
    base = 16'h0126;
    pulse_prefetch(base, 6'd14, 6'd32);
    for (int k = 0; k < 4; k++) begin
      fill[k]   = {$urandom, $urandom};
      ddr_we    = 1'b1;
      ddr_waddr = buf_addr_t'(k);
      ddr_wdata = fill[k];
      tick();
    end
    ddr_we = 1'b0;
    for (int i = 0; i < 14; i++) begin
      mem_addr = base + addr_t'(i);
      tick();
      tick();
      check("mem_rdata", mem_rdata,
            fill[i/`RATE][`BWIDTH-1-(i%`RATE)*`DWIDTH -: `DWIDTH]);
    end
  endtask

  task automatic full_write();
    write_and_drain(16'h0400, 32);
  endtask

  task automatic partial_write();
    pulse_prefetch(16'h0120, 6'd14, 6'd6);
    write_and_drain(16'h0500, 6);
  endtask

  // the bypass has to win over the prefetch word
  task automatic read_bypass();
    addr_t base;
    base = 16'h0600;
    for (int i = 0; i < 6; i++) begin
      words[i]  = `DWIDTH'($urandom);
      mem_we    = 1'b1;
      mem_addr  = base + addr_t'(i);
      mem_wdata = words[i];
      tick();
      mem_we   = 1'b0;
      mem_addr = 16'h0120 + addr_t'(i);
      tick();
      check("mem_rdata", mem_rdata, words[i]);
    end
    while (ddr_req !== 1'b1) begin
      tick();
    end
    check_req(DDR_WRITE, base, 6'd2);
    tick();
  endtask

  task automatic request_collision();
    write_words(16'h0700, 6);
    mem_we   = 1'b0;
    pre_en   = 1'b1;
    pre_base = 16'h0140;
    tick();
    pre_en = 1'b0;
    // a new first word moves the packer base while the write is held
    mem_we    = 1'b1;
    mem_addr  = 16'h0800;
    mem_wdata = `DWIDTH'($urandom);
    tick();
    mem_we = 1'b0;
    check_req(DDR_READ, 16'h0140, 6'd4);
    tick();
    check_req(DDR_WRITE, 16'h0700, 6'd2);
    tick();
    check("ddr_req", ddr_req, 1'b0);
  endtask

  initial begin
    void'($urandom(SEED));
    xrst      = 1'b0;
    pre_en    = 1'b0;
    pre_base  = '0;
    read_len  = '0;
    write_len = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    ddr_we    = 1'b0;
    ddr_waddr = '0;
    ddr_wdata = '0;
    ddr_raddr = '0;
    repeat (10) @(posedge clk);
    #2;
    xrst = 1'b1;
    tick();
    reset_values();
    prefetch_fill_read();
    full_write();
    partial_write();
    read_bypass();
    request_collision();
    tick();
    if (ddr_buf_top_inst.ddr_buf_props_inst.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("%0d assertion failures during the run",
               ddr_buf_top_inst.ddr_buf_props_inst.fail_count);
      $display("Simulation failed");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/ddr_buf_pkg.sv
rtl/ddr_burst_if.sv
rtl/sp_ram.sv
rtl/prefetch_buffer.sv
rtl/write_packer.sv
rtl/buffer_port_mux.sv
rtl/ddr_buf_top.sv
verif/ddr_buf_props.sv
verif/tb_ddr_buf.sv
